// File: hw/cap_check_params.svh
// Widths, port indices, otype and permission bit positions for the capability checker
`ifndef CAP_CHECK_PARAMS_SVH
`define CAP_CHECK_PARAMS_SVH

// Address and capability field widths
`define ADDR_W         32
`define CAP_BASE_W     32
`define CAP_LEN_W      20
`define CAP_PERM_W     8
`define CAP_OTYPE_W    4
`define OTYPE_UNSEALED 4'hF

// Memory word and byte lanes
`define MEM_W          64
`define LANES          8

// Check ports
`define NUM_PORTS      2
`define PORT_INSTR     0
`define PORT_DATA      1

// Exception vector width
`define EXC_W          5

// Permission bits, top bit of perms holds the tag
`define PERM_LOAD      0
`define PERM_STORE     1
`define PERM_EXEC      2
`define PERM_LOAD_CAP  3
`define PERM_STORE_CAP 4

`endif

// File: hw/cap_check_pkg.sv
// Capability, memory word, request, result, cause and load control types
`default_nettype none

`include "cap_check_params.svh"

package cap_check_pkg;

  ////////////////////////////////////////////////////////////
  // Capability and memory word
  ////////////////////////////////////////////////////////////

  // One capability word, perms in the top byte
  typedef struct packed {
    logic [`CAP_PERM_W-1:0]  perms;
    logic [`CAP_OTYPE_W-1:0] otype;
    logic [`CAP_LEN_W-1:0]   length;
    logic [`CAP_BASE_W-1:0]  base;
  } cap_fields_t;

  typedef struct packed {
    logic [`MEM_W/2-1:0] hi;
    logic [`MEM_W/2-1:0] lo;
  } mem_int_t;

  // Returned word, seen as a capability or as two integer words
  typedef union packed {
    cap_fields_t as_cap;
    mem_int_t    as_int;
  } mem_word_u;

  typedef enum logic [1:0] {
    DT_WORD = 2'd0,
    DT_HALF = 2'd1,
    DT_BYTE = 2'd2,
    DT_CAP  = 2'd3
  } data_type_e;

  ////////////////////////////////////////////////////////////
  // Check requests and results
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                   valid;
    logic [`ADDR_W-1:0]     addr;
    logic [$clog2(`LANES):0] nbytes;
    logic                   write;
    logic                   cap_access;
    cap_fields_t            auth;
  } access_req_t;

  typedef struct packed {
    logic tag;
    logic seal;
    logic perm;
    logic length;
    logic align;
  } exc_vec_t;

  typedef struct packed {
    logic     valid;
    exc_vec_t exc;
  } chk_result_t;

  typedef enum logic [2:0] {
    CAUSE_NONE   = 3'd0,
    CAUSE_TAG    = 3'd1,
    CAUSE_SEAL   = 3'd2,
    CAUSE_PERM   = 3'd3,
    CAUSE_LENGTH = 3'd4,
    CAUSE_ALIGN  = 3'd5
  } exc_cause_e;

  // Data request fields kept for the load return
  typedef struct packed {
    data_type_e                dtype;
    logic                      sign_ext;
    logic [$clog2(`LANES)-1:0] offset;
  } load_ctl_t;

endpackage

`default_nettype wire

// File: hw/access_request_gen.sv
// Request builder for the fetch and data check ports, with data byte enables
`timescale 1ns/10ps
`default_nettype none

`include "cap_check_params.svh"

module access_request_gen import cap_check_pkg::*; (
  // Instruction fetch
  input  logic                               fetch_req_i,
  input  logic [`ADDR_W-1:0]                 fetch_addr_i,
  input  cap_fields_t                        pcc_i,
  // Data access
  input  logic                               data_req_i,
  input  logic [`ADDR_W-1:0]                 data_addr_i,
  input  logic                               data_we_i,
  input  data_type_e                         data_type_i,
  input  logic                               data_sign_ext_i,
  input  cap_fields_t                        data_cap_i,
  // To checkers and response path
  output access_req_t [`NUM_PORTS-1:0]       req_o,
  output logic [`LANES-1:0]                  data_be_o,
  output load_ctl_t                          load_ctl_o
);

  logic [$clog2(`LANES):0]   data_nbytes;
  logic [$clog2(`LANES)-1:0] data_offset;
  logic [`LANES-1:0]         data_mask;

  // Access size to byte count
  always_comb begin
    unique case (data_type_i)
      DT_WORD: data_nbytes = 4'd4;
      DT_HALF: data_nbytes = 4'd2;
      DT_BYTE: data_nbytes = 4'd1;
      DT_CAP:  data_nbytes = 4'd8;
      default: data_nbytes = 4'd4;
    endcase
  end

  assign data_offset = data_addr_i[$clog2(`LANES)-1:0];

  // Lanes shifted past the top are dropped, misalignment is flagged by the checker
  assign data_mask = `LANES'((16'd1 << data_nbytes) - 16'd1);
  assign data_be_o = data_mask << data_offset;

  ////////////////////////////////////////////////////////////
  // Port requests
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Fetch is always a plain 4 byte read
    req_o[`PORT_INSTR].valid      = fetch_req_i;
    req_o[`PORT_INSTR].addr       = fetch_addr_i;
    req_o[`PORT_INSTR].nbytes     = 4'd4;
    req_o[`PORT_INSTR].write      = 1'b0;
    req_o[`PORT_INSTR].cap_access = 1'b0;
    req_o[`PORT_INSTR].auth       = pcc_i;

    req_o[`PORT_DATA].valid       = data_req_i;
    req_o[`PORT_DATA].addr        = data_addr_i;
    req_o[`PORT_DATA].nbytes      = data_nbytes;
    req_o[`PORT_DATA].write       = data_we_i;
    req_o[`PORT_DATA].cap_access  = (data_type_i == DT_CAP);
    req_o[`PORT_DATA].auth        = data_cap_i;
  end

  // Formatting info for the returning load
  assign load_ctl_o.dtype    = data_type_i;
  assign load_ctl_o.sign_ext = data_sign_ext_i;
  assign load_ctl_o.offset   = data_offset;

endmodule

`default_nettype wire

// File: hw/cap_bounds_checker.sv
// Tag, seal, permission, bounds and alignment check of one access against its capability
`timescale 1ns/10ps
`default_nettype none

`include "cap_check_params.svh"

module cap_bounds_checker import cap_check_pkg::*; (
  input  access_req_t req_i,
  output exc_vec_t    exc_o
);

  logic [`CAP_PERM_W-1:0]    perms;
  logic [$clog2(`LANES)-1:0] offset;
  logic [$clog2(`LANES):0]   lane_end;
  logic [`ADDR_W:0]          access_end;
  logic [`ADDR_W:0]          cap_top;
  logic                      perm_ok;
  logic                      below_base;
  logic                      above_top;

  assign perms  = req_i.auth.perms;
  assign offset = req_i.addr[$clog2(`LANES)-1:0];

  ////////////////////////////////////////////////////////////
  // Permissions
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (req_i.write) begin
      perm_ok = perms[`PERM_STORE];
      if (req_i.cap_access) begin
        perm_ok = perm_ok & perms[`PERM_STORE_CAP];
      end
    end else begin
      // Fetches and loads share the read path, either right is enough
      perm_ok = perms[`PERM_LOAD] | perms[`PERM_EXEC];
      if (req_i.cap_access) begin
        perm_ok = perm_ok & perms[`PERM_LOAD_CAP];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Bounds
  ////////////////////////////////////////////////////////////

  // One extra bit so top of region never wraps
  assign access_end = {1'b0, req_i.addr} + (`ADDR_W + 1)'(req_i.nbytes);
  assign cap_top    = {1'b0, req_i.auth.base} + (`ADDR_W + 1)'(req_i.auth.length);

  assign below_base = req_i.addr < req_i.auth.base;
  assign above_top  = access_end > cap_top;

  // Access must stay inside one memory word
  assign lane_end = {1'b0, offset} + req_i.nbytes;

  ////////////////////////////////////////////////////////////
  // Exception vector
  ////////////////////////////////////////////////////////////

  always_comb begin
    exc_o = '0;
    if (req_i.valid) begin
      // Reserved top permission bit carries the tag
      exc_o.tag    = ~perms[`CAP_PERM_W-1];
      exc_o.seal   = req_i.auth.otype != `OTYPE_UNSEALED;
      exc_o.perm   = ~perm_ok;
      exc_o.length = below_base | above_top;
      exc_o.align  = (lane_end > `LANES) | (req_i.cap_access & (offset != '0));
    end
  end

endmodule

`default_nettype wire

// File: hw/access_response_unit.sv
// Registered check results with cause encoding, and load data formatting
`timescale 1ns/10ps
`default_nettype none

`include "cap_check_params.svh"

module access_response_unit import cap_check_pkg::*; (
  input  logic                          clk,
  input  logic                          rst_ni,
  // From checkers
  input  logic [`NUM_PORTS-1:0]         req_valid_i,
  input  exc_vec_t [`NUM_PORTS-1:0]     exc_i,
  // From request builder
  input  load_ctl_t                     load_ctl_i,
  input  logic                          data_req_i,
  // Memory return
  input  logic                          data_rvalid_i,
  input  mem_word_u                     data_rdata_i,
  input  logic                          data_rtag_i,
  // Results
  output chk_result_t                   instr_chk_o,
  output chk_result_t                   data_chk_o,
  output exc_cause_e                    instr_cause_o,
  output exc_cause_e                    data_cause_o,
  output logic                          load_valid_o,
  output logic [`MEM_W/2-1:0]           load_data_o,
  output cap_fields_t                   load_cap_o,
  output logic                          load_tag_o
);

  chk_result_t [`NUM_PORTS-1:0] chk_q;
  exc_cause_e  [`NUM_PORTS-1:0] cause_q;
  load_ctl_t                    load_ctl_q;
  logic [`MEM_W/2-1:0]          word_sel;
  logic [`MEM_W/2-1:0]          word_shift;
  logic [`MEM_W/2-1:0]          int_data;
  logic                         is_cap;

  // First set bit wins, tag highest
  function automatic exc_cause_e encode_cause(logic [`EXC_W-1:0] bits);
    exc_vec_t exc;
    exc = exc_vec_t'(bits);
    if (exc.tag) begin
      return CAUSE_TAG;
    end else if (exc.seal) begin
      return CAUSE_SEAL;
    end else if (exc.perm) begin
      return CAUSE_PERM;
    end else if (exc.length) begin
      return CAUSE_LENGTH;
    end else if (exc.align) begin
      return CAUSE_ALIGN;
    end
    return CAUSE_NONE;
  endfunction

  ////////////////////////////////////////////////////////////
  // Per-port result registers
  ////////////////////////////////////////////////////////////

  for (genvar p = 0; p < `NUM_PORTS; p++) begin : g_port_reg
    always_ff @(posedge clk or negedge rst_ni) begin
      if (!rst_ni) begin
        chk_q[p]   <= '0;
        cause_q[p] <= CAUSE_NONE;
      end else begin
        chk_q[p].valid <= req_valid_i[p];
        chk_q[p].exc   <= exc_i[p];
        cause_q[p]     <= encode_cause(exc_i[p]);
      end
    end
  end

  assign instr_chk_o   = chk_q[`PORT_INSTR];
  assign data_chk_o    = chk_q[`PORT_DATA];
  assign instr_cause_o = cause_q[`PORT_INSTR];
  assign data_cause_o  = cause_q[`PORT_DATA];

  ////////////////////////////////////////////////////////////
  // Load return
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      load_ctl_q   <= '0;
      load_valid_o <= 1'b0;
    end else begin
      if (data_req_i) begin
        load_ctl_q <= load_ctl_i;
      end
      load_valid_o <= data_rvalid_i;
    end
  end

  assign is_cap = (load_ctl_q.dtype == DT_CAP);

  // Upper or lower word, then down to the addressed byte
  assign word_sel   = load_ctl_q.offset[2] ? data_rdata_i.as_int.hi : data_rdata_i.as_int.lo;
  assign word_shift = word_sel >> {load_ctl_q.offset[1:0], 3'b000};

  always_comb begin
    unique case (load_ctl_q.dtype)
      DT_HALF: int_data = {{16{load_ctl_q.sign_ext & word_shift[15]}}, word_shift[15:0]};
      DT_BYTE: int_data = {{24{load_ctl_q.sign_ext & word_shift[7]}}, word_shift[7:0]};
      DT_CAP:  int_data = data_rdata_i.as_int.lo;
      default: int_data = word_shift;
    endcase
  end

  always_ff @(posedge clk) begin
    if (data_rvalid_i) begin
      load_data_o <= int_data;
      load_cap_o  <= is_cap ? data_rdata_i.as_cap : '0;
      // Integer loads never yield a valid capability
      load_tag_o  <= is_cap & data_rtag_i;
    end
  end

endmodule

`default_nettype wire

// File: hw/cap_mem_check_top.sv
// Top level of the capability checked memory access port
`timescale 1ns/10ps
`default_nettype none

`include "cap_check_params.svh"

module cap_mem_check_top import cap_check_pkg::*; (
  input  logic                clk,
  input  logic                rst_ni,
  // Instruction fetch
  input  logic                fetch_req_i,
  input  logic [`ADDR_W-1:0]  fetch_addr_i,
  input  cap_fields_t         pcc_i,
  // Data access
  input  logic                data_req_i,
  input  logic [`ADDR_W-1:0]  data_addr_i,
  input  logic                data_we_i,
  input  data_type_e          data_type_i,
  input  logic                data_sign_ext_i,
  input  cap_fields_t         data_cap_i,
  output logic [`LANES-1:0]   data_be_o,
  // Memory return
  input  logic                data_rvalid_i,
  input  mem_word_u           data_rdata_i,
  input  logic                data_rtag_i,
  // Results
  output chk_result_t         instr_chk_o,
  output chk_result_t         data_chk_o,
  output exc_cause_e          instr_cause_o,
  output exc_cause_e          data_cause_o,
  output logic                load_valid_o,
  output logic [`MEM_W/2-1:0] load_data_o,
  output cap_fields_t         load_cap_o,
  output logic                load_tag_o
);

  access_req_t [`NUM_PORTS-1:0] port_req;
  exc_vec_t    [`NUM_PORTS-1:0] port_exc;
  logic        [`NUM_PORTS-1:0] port_valid;
  load_ctl_t                    load_ctl;

  access_request_gen u_request_gen (
    .fetch_req_i     ( fetch_req_i     ),
    .fetch_addr_i    ( fetch_addr_i    ),
    .pcc_i           ( pcc_i           ),
    .data_req_i      ( data_req_i      ),
    .data_addr_i     ( data_addr_i     ),
    .data_we_i       ( data_we_i       ),
    .data_type_i     ( data_type_i     ),
    .data_sign_ext_i ( data_sign_ext_i ),
    .data_cap_i      ( data_cap_i      ),
    .req_o           ( port_req        ),
    .data_be_o       ( data_be_o       ),
    .load_ctl_o      ( load_ctl        )
  );

  // Port 0 checks fetches, port 1 checks data
  for (genvar p = 0; p < `NUM_PORTS; p++) begin : g_checker
    cap_bounds_checker u_checker (
      .req_i ( port_req[p] ),
      .exc_o ( port_exc[p] )
    );
    assign port_valid[p] = port_req[p].valid;
  end

  access_response_unit u_response (
    .clk           ( clk           ),
    .rst_ni        ( rst_ni        ),
    .req_valid_i   ( port_valid    ),
    .exc_i         ( port_exc      ),
    .load_ctl_i    ( load_ctl      ),
    .data_req_i    ( data_req_i    ),
    .data_rvalid_i ( data_rvalid_i ),
    .data_rdata_i  ( data_rdata_i  ),
    .data_rtag_i   ( data_rtag_i   ),
    .instr_chk_o   ( instr_chk_o   ),
    .data_chk_o    ( data_chk_o    ),
    .instr_cause_o ( instr_cause_o ),
    .data_cause_o  ( data_cause_o  ),
    .load_valid_o  ( load_valid_o  ),
    .load_data_o   ( load_data_o   ),
    .load_cap_o    ( load_cap_o    ),
    .load_tag_o    ( load_tag_o    )
  );

endmodule

`default_nettype wire

// File: dv/cap_check_model.svh
// Reference model of byte counts, lane masks, access faults, cause priority and load formatting
`ifndef CAP_CHECK_MODEL_SVH
`define CAP_CHECK_MODEL_SVH

function automatic int unsigned byte_count(data_type_e dtype);
  case (dtype)
    DT_HALF: return 2;
    DT_BYTE: return 1;
    DT_CAP:  return 8;
    default: return 4;
  endcase
endfunction

// Lanes from offset up to offset plus size, nothing beyond lane 7
function automatic logic [`LANES-1:0] lane_mask(int unsigned offset, int unsigned nbytes);
  logic [`LANES-1:0] mask;
  mask = '0;
  for (int unsigned i = 0; i < `LANES; i++) begin
    mask[i] = (i >= offset) && (i < offset + nbytes);
  end
  return mask;
endfunction

function automatic exc_vec_t access_faults(logic valid, logic [`ADDR_W-1:0] addr,
                                           int unsigned nbytes, logic write,
                                           logic cap_access, cap_fields_t cap);
  exc_vec_t        exc;
  logic            allowed;
  longint unsigned access_top;
  longint unsigned region_top;
  exc = '0;
  if (valid) begin
    if (write) begin
      allowed = cap.perms[`PERM_STORE] && (!cap_access || cap.perms[`PERM_STORE_CAP]);
    end else begin
      allowed = (cap.perms[`PERM_LOAD] || cap.perms[`PERM_EXEC]) &&
                (!cap_access || cap.perms[`PERM_LOAD_CAP]);
    end
    // Wide sums, so a region near the top of memory does not wrap
    access_top = 64'(addr) + 64'(nbytes);
    region_top = 64'(cap.base) + 64'(cap.length);
    exc.tag    = !cap.perms[`CAP_PERM_W-1];
    exc.seal   = (cap.otype != `OTYPE_UNSEALED);
    exc.perm   = !allowed;
    exc.length = (addr < cap.base) || (access_top > region_top);
    exc.align  = (32'(addr[2:0]) + nbytes > `LANES) || (cap_access && (addr[2:0] != 3'b000));
  end
  return exc;
endfunction

function automatic exc_cause_e fault_cause(exc_vec_t exc);
  if (exc.tag) return CAUSE_TAG;
  if (exc.seal) return CAUSE_SEAL;
  if (exc.perm) return CAUSE_PERM;
  if (exc.length) return CAUSE_LENGTH;
  if (exc.align) return CAUSE_ALIGN;
  return CAUSE_NONE;
endfunction

function automatic logic [31:0] format_load(mem_word_u rdata, load_ctl_t ctl);
  logic [31:0] word;
  word = ctl.offset[2] ? rdata.as_int.hi : rdata.as_int.lo;
  word = word >> (8 * ctl.offset[1:0]);
  case (ctl.dtype)
    DT_CAP:  return rdata.as_int.lo;
    DT_HALF: return ctl.sign_ext ? 32'($signed(word[15:0])) : 32'(word[15:0]);
    DT_BYTE: return ctl.sign_ext ? 32'($signed(word[7:0])) : 32'(word[7:0]);
    default: return word;
  endcase
endfunction

`endif

// File: dv/cap_check_tb.sv
// Testbench for the capability checked memory port with random stimulus and a reference model
`timescale 1ns/10ps
`default_nettype none

`include "cap_check_params.svh"

module cap_check_tb import cap_check_pkg::*; ();

  `include "cap_check_model.svh"

  localparam int unsigned NUM_CYCLES    = 4000;
  localparam int unsigned RESET_TIMEOUT = 50;

  logic               clk = 1'b0;
  logic               rst_ni;
  logic               fetch_req_i;
  logic [`ADDR_W-1:0] fetch_addr_i;
  cap_fields_t        pcc_i;
  logic               data_req_i;
  logic [`ADDR_W-1:0] data_addr_i;
  logic               data_we_i;
  data_type_e         data_type_i;
  logic               data_sign_ext_i;
  cap_fields_t        data_cap_i;
  logic [`LANES-1:0]  data_be_o;
  logic               data_rvalid_i;
  mem_word_u          data_rdata_i;
  logic               data_rtag_i;
  chk_result_t        instr_chk_o;
  chk_result_t        data_chk_o;
  exc_cause_e         instr_cause_o;
  exc_cause_e         data_cause_o;
  logic               load_valid_o;
  logic [31:0]        load_data_o;
  cap_fields_t        load_cap_o;
  logic               load_tag_o;

  // Expected registered outputs for the next falling edge
  chk_result_t exp_instr_chk;
  chk_result_t exp_data_chk;
  exc_cause_e  exp_instr_cause;
  exc_cause_e  exp_data_cause;
  logic        exp_load_valid;
  logic [31:0] exp_load_data;
  cap_fields_t exp_load_cap;
  logic        exp_load_tag;
  load_ctl_t   model_ctl;

  cap_mem_check_top dut0 (.*);

  always #20 clk = ~clk;

  initial begin
    rst_ni = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_ni = 1'b1;
  end

  initial begin
    #(40 * (NUM_CYCLES + 100));
    $display("simulation ran past its cycle limit");
    $display("tests failed");
    $fatal(1);
  end

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Random capabilities and addresses near their edges
  ////////////////////////////////////////////////////////////

  function automatic cap_fields_t make_cap();
    cap_fields_t cap;
    cap.base   = $urandom;
    cap.length = ($urandom_range(7, 0) == 0) ? 20'($urandom) : 20'($urandom_range(96, 0));
    if ($urandom_range(1, 0) == 0) begin
      cap.base[2:0]   = 3'b000;
      cap.length[2:0] = 3'b000;
    end
    // Regions ending past 4 GiB
    if ($urandom_range(15, 0) == 0) begin
      cap.base = 32'hffff_ffff - 32'($urandom_range(63, 0));
    end
    cap.otype = ($urandom_range(7, 0) == 0) ? 4'($urandom) : `OTYPE_UNSEALED;
    cap.perms = 8'($urandom);
    if ($urandom_range(2, 0) != 0) begin
      cap.perms[4:0] = 5'h1f;
    end
    cap.perms[`CAP_PERM_W-1] = ($urandom_range(7, 0) != 0);
    return cap;
  endfunction

  function automatic logic [`ADDR_W-1:0] pick_addr(cap_fields_t cap, int unsigned nbytes);
    logic [`ADDR_W-1:0] top;
    top = cap.base + 32'(cap.length);
    case ($urandom_range(4, 0))
      0: return top - 32'(nbytes);
      1: return top - 32'(nbytes) + 32'd1;
      2: return cap.base - 32'($urandom_range(8, 1));
      3: return cap.base + 32'($urandom_range(32'(cap.length), 0));
      default: return $urandom;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int unsigned waited;
    int unsigned nbytes;
    exc_vec_t    exc;
    void'($urandom(87));
    fetch_req_i     = 1'b0;
    fetch_addr_i    = '0;
    pcc_i           = '0;
    data_req_i      = 1'b0;
    data_addr_i     = '0;
    data_we_i       = 1'b0;
    data_type_i     = DT_WORD;
    data_sign_ext_i = 1'b0;
    data_cap_i      = '0;
    data_rvalid_i   = 1'b0;
    data_rdata_i    = '0;
    data_rtag_i     = 1'b0;
    exp_instr_chk   = '0;
    exp_data_chk    = '0;
    exp_instr_cause = CAUSE_NONE;
    exp_data_cause  = CAUSE_NONE;
    exp_load_valid  = 1'b0;
    exp_load_data   = '0;
    exp_load_cap    = '0;
    exp_load_tag    = 1'b0;
    model_ctl       = '0;

    waited = 0;
    while (rst_ni !== 1'b1) begin
      if (waited == RESET_TIMEOUT) begin
        $display("reset was not released within the timeout");
        $display("tests failed");
        $fatal(1);
      end
      waited++;
      @(negedge clk);
    end

    // Idle outputs right after reset
    #1;
    check_value("instr_chk_o.valid", 128'd0, 128'(instr_chk_o.valid));
    check_value("data_chk_o.valid", 128'd0, 128'(data_chk_o.valid));
    check_value("load_valid_o", 128'd0, 128'(load_valid_o));
    check_value("instr_cause_o", 128'(CAUSE_NONE), 128'(instr_cause_o));
    check_value("data_cause_o", 128'(CAUSE_NONE), 128'(data_cause_o));

    for (int unsigned cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      @(negedge clk);
      check_value("instr_chk_o", 128'(exp_instr_chk), 128'(instr_chk_o));
      check_value("data_chk_o", 128'(exp_data_chk), 128'(data_chk_o));
      check_value("instr_cause_o", 128'(exp_instr_cause), 128'(instr_cause_o));
      check_value("data_cause_o", 128'(exp_data_cause), 128'(data_cause_o));
      check_value("load_valid_o", 128'(exp_load_valid), 128'(load_valid_o));
      if (exp_load_valid) begin
        check_value("load_data_o", 128'(exp_load_data), 128'(load_data_o));
        check_value("load_cap_o", 128'(exp_load_cap), 128'(load_cap_o));
        check_value("load_tag_o", 128'(exp_load_tag), 128'(load_tag_o));
      end

      fetch_req_i     = ($urandom_range(1, 0) == 0);
      pcc_i           = make_cap();
      fetch_addr_i    = pick_addr(pcc_i, 4);
      data_req_i      = ($urandom_range(1, 0) == 0);
      data_type_i     = data_type_e'($urandom_range(3, 0));
      nbytes          = byte_count(data_type_i);
      data_cap_i      = make_cap();
      data_addr_i     = pick_addr(data_cap_i, nbytes);
      if ((data_type_i == DT_CAP) && ($urandom_range(1, 0) == 0)) begin
        data_addr_i[2:0] = 3'b000;
      end
      data_we_i       = ($urandom_range(2, 0) == 0);
      data_sign_ext_i = ($urandom_range(1, 0) == 0);
      data_rvalid_i   = ($urandom_range(2, 0) == 0);
      data_rdata_i    = {$urandom, $urandom};
      data_rtag_i     = ($urandom_range(1, 0) == 0);

      // Byte enables are combinational
      #1;
      check_value("data_be_o", 128'(lane_mask(32'(data_addr_i[2:0]), nbytes)),
                  128'(data_be_o));

      exc                   = access_faults(fetch_req_i, fetch_addr_i, 4, 1'b0, 1'b0, pcc_i);
      exp_instr_chk.valid   = fetch_req_i;
      exp_instr_chk.exc     = exc;
      exp_instr_cause       = fault_cause(exc);
      exc                   = access_faults(data_req_i, data_addr_i, nbytes, data_we_i,
                                            data_type_i == DT_CAP, data_cap_i);
      exp_data_chk.valid    = data_req_i;
      exp_data_chk.exc      = exc;
      exp_data_cause        = fault_cause(exc);

      // A return uses the control of the request captured before this edge
      exp_load_valid = data_rvalid_i;
      if (data_rvalid_i) begin
        exp_load_data = format_load(data_rdata_i, model_ctl);
        exp_load_cap  = (model_ctl.dtype == DT_CAP) ? data_rdata_i.as_cap : '0;
        exp_load_tag  = (model_ctl.dtype == DT_CAP) && data_rtag_i;
      end
      if (data_req_i) begin
        model_ctl.dtype    = data_type_i;
        model_ctl.sign_ext = data_sign_ext_i;
        model_ctl.offset   = data_addr_i[2:0];
      end
    end

    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+hw
+incdir+dv
hw/cap_check_pkg.sv
hw/access_request_gen.sv
hw/cap_bounds_checker.sv
hw/access_response_unit.sv
hw/cap_mem_check_top.sv
dv/cap_check_tb.sv

// File: Makefile
SIM      = verilator
SIMFLAGS = --binary --timing -j 0
TOP      = cap_check_tb
FILELIST = build.f
OBJDIR   = obj_dir
LOG      = sim.log
PASS_MSG = all tests passed

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
